//--- common/axil_pkg.sv
package axil_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // bus widths
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int PROT_WIDTH = 3;
    localparam int RESP_WIDTH = 2;

    typedef logic [ADDR_WIDTH-1:0] addr_t;  // byte address.
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;  // one bit per byte lane.
    typedef logic [PROT_WIDTH-1:0] prot_t;
    typedef logic [RESP_WIDTH-1:0] resp_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // response codes
    // ~~~~~~~~~~~~~~~~~~~~

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;  // no slave at that address.

endpackage

//--- common/ctrl_map_pkg.sv
package ctrl_map_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // control address map
    // ~~~~~~~~~~~~~~~~~~~~

    // slave 0 window starts here, the rest follow back to back.
    localparam axil_pkg::addr_t CTRL_BASE_ADDR = 32'h43c0_0000;

    // one 64 KiB window per slave.
    localparam axil_pkg::addr_t SLAVE_SPAN = 32'h0001_0000;

    localparam int SLAVE_NUM_MAX = 8;

    typedef logic [$clog2(SLAVE_NUM_MAX)-1:0] slave_idx_t;  // selects one window.

endpackage

//--- reg_bank/axil_reg_bank.sv
module axil_reg_bank #(
    parameter int REG_NUM = 4
) (
    input  logic clk_i,
    input  logic rst_i,

    input  logic            wr_valid_i,
    output logic            wr_ready_o,
    input  axil_pkg::addr_t wr_addr_i,
    input  axil_pkg::data_t wr_data_i,
    input  axil_pkg::strb_t wr_strb_i,

    output logic bvalid_o,
    input  logic bready_i,

    input  logic            rd_valid_i,
    output logic            rd_ready_o,
    input  axil_pkg::addr_t rd_addr_i,

    output logic            rvalid_o,
    output axil_pkg::data_t rdata_o,
    input  logic            rready_i
);

    import axil_pkg::*;

    localparam int IDX_W = $clog2(REG_NUM);

    typedef logic [IDX_W-1:0] reg_idx_t;

    data_t    regs [REG_NUM];
    reg_idx_t wr_idx;
    reg_idx_t rd_idx;
    logic     wr_acc;
    logic     rd_acc;

    // word index, upper offset bits alias.
    assign wr_idx = wr_addr_i[2+:IDX_W];
    assign rd_idx = rd_addr_i[2+:IDX_W];

    // one response at a time per direction.
    assign wr_ready_o = !bvalid_o;
    assign rd_ready_o = !rvalid_o;

    assign wr_acc = wr_valid_i && wr_ready_o;
    assign rd_acc = rd_valid_i && rd_ready_o;

    // ~~~~~~~~~~~~~~~~~~~~
    // write side
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bvalid_o <= 1'b0;
            for (int r = 0; r < REG_NUM; r++) begin
                regs[r] <= '0;  // registers read back zero after reset.
            end
        end else begin
            if (wr_acc) begin
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (wr_strb_i[b]) regs[wr_idx][8*b+:8] <= wr_data_i[8*b+:8];
                end
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read side
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_o <= 1'b0;
        end else if (rd_acc) begin
            rvalid_o <= 1'b1;
        end else if (rready_i) begin
            rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_acc) rdata_o <= regs[rd_idx];  // held until taken.
    end

endmodule

//--- verilog/axil_addr_decode.sv
module axil_addr_decode #(
    parameter int SLAVE_NUM = 3
) (
    input  logic clk_i,
    input  logic rst_i,

    input  axil_pkg::addr_t awaddr_i,
    input  logic            awvalid_i,
    output logic            awready_o,
    input  axil_pkg::data_t wdata_i,
    input  axil_pkg::strb_t wstrb_i,
    input  logic            wvalid_i,
    output logic            wready_o,
    input  axil_pkg::addr_t araddr_i,
    input  logic            arvalid_i,
    output logic            arready_o,

    output logic [SLAVE_NUM-1:0] wr_req_valid_o,
    input  logic [SLAVE_NUM-1:0] wr_req_ready_i,
    output axil_pkg::addr_t      wr_addr_o,
    output axil_pkg::data_t      wr_data_o,
    output axil_pkg::strb_t      wr_strb_o,
    output logic [SLAVE_NUM-1:0] rd_req_valid_o,
    input  logic [SLAVE_NUM-1:0] rd_req_ready_i,
    output axil_pkg::addr_t      rd_addr_o,

    output logic                     wr_miss_o,
    output logic                     rd_miss_o,
    output ctrl_map_pkg::slave_idx_t wr_sel_o,
    output ctrl_map_pkg::slave_idx_t rd_sel_o,
    input  logic                     wr_done_i,
    input  logic                     rd_done_i
);

    import axil_pkg::*;
    import ctrl_map_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FWD,
        WAIT
    } state_t;

    state_t wr_state;
    state_t rd_state;

    addr_t      wr_addr_q;
    data_t      wr_data_q;
    strb_t      wr_strb_q;
    slave_idx_t wr_sel_q;
    logic       wr_miss_q;
    addr_t      rd_addr_q;
    slave_idx_t rd_sel_q;
    logic       rd_miss_q;

    logic wr_hs;
    logic rd_hs;
    logic wr_acc;
    logic rd_acc;

    // offset wraps for addresses below the base, so one compare covers both ends.
    function automatic logic addr_hit(input addr_t addr);
        addr_t offset;
        offset = addr - CTRL_BASE_ADDR;
        return offset < (addr_t'(SLAVE_NUM) * SLAVE_SPAN);
    endfunction

    function automatic slave_idx_t addr_idx(input addr_t addr);
        addr_t window;
        window = (addr - CTRL_BASE_ADDR) / SLAVE_SPAN;
        return slave_idx_t'(window);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // master handshakes
    // ~~~~~~~~~~~~~~~~~~~~

    assign wr_hs     = (wr_state == IDLE) && awvalid_i && wvalid_i;  // aw and w together.
    assign awready_o = wr_hs;
    assign wready_o  = wr_hs;
    assign rd_hs     = (rd_state == IDLE) && arvalid_i;
    assign arready_o = rd_hs;

    always_comb begin
        for (int i = 0; i < SLAVE_NUM; i++) begin
            wr_req_valid_o[i] = (wr_state == FWD) && !wr_miss_q && (wr_sel_q == slave_idx_t'(i));
            rd_req_valid_o[i] = (rd_state == FWD) && !rd_miss_q && (rd_sel_q == slave_idx_t'(i));
        end
    end

    assign wr_miss_o = (wr_state == FWD) && wr_miss_q;
    assign rd_miss_o = (rd_state == FWD) && rd_miss_q;

    // the mux takes a miss at once.
    assign wr_acc = wr_miss_o || (|(wr_req_valid_o & wr_req_ready_i));
    assign rd_acc = rd_miss_o || (|(rd_req_valid_o & rd_req_ready_i));

    assign wr_addr_o = wr_addr_q;
    assign wr_data_o = wr_data_q;
    assign wr_strb_o = wr_strb_q;
    assign wr_sel_o  = wr_sel_q;
    assign rd_addr_o = rd_addr_q;
    assign rd_sel_o  = rd_sel_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // state machines
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_state <= IDLE;
        end else begin
            case (wr_state)
                IDLE:    if (wr_hs) wr_state <= FWD;
                FWD:     if (wr_acc) wr_state <= WAIT;
                WAIT:    if (wr_done_i) wr_state <= IDLE;  // B handshake seen.
                default: wr_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_state <= IDLE;
        end else begin
            case (rd_state)
                IDLE:    if (rd_hs) rd_state <= FWD;
                FWD:     if (rd_acc) rd_state <= WAIT;
                WAIT:    if (rd_done_i) rd_state <= IDLE;
                default: rd_state <= IDLE;
            endcase
        end
    end

    // forward stage, loaded on the master handshake.
    always_ff @(posedge clk_i) begin
        if (wr_hs) begin
            wr_addr_q <= awaddr_i;
            wr_data_q <= wdata_i;
            wr_strb_q <= wstrb_i;
            wr_sel_q  <= addr_idx(awaddr_i);
            wr_miss_q <= !addr_hit(awaddr_i);
        end
        if (rd_hs) begin
            rd_addr_q <= araddr_i;
            rd_sel_q  <= addr_idx(araddr_i);
            rd_miss_q <= !addr_hit(araddr_i);
        end
    end

endmodule

//--- verilog/axil_resp_mux.sv
module axil_resp_mux #(
    parameter int SLAVE_NUM = 3
) (
    input  logic clk_i,
    input  logic rst_i,

    input  ctrl_map_pkg::slave_idx_t wr_sel_i,
    input  ctrl_map_pkg::slave_idx_t rd_sel_i,
    input  logic                     wr_miss_i,
    input  logic                     rd_miss_i,

    input  logic [SLAVE_NUM-1:0]            bank_bvalid_i,
    output logic [SLAVE_NUM-1:0]            bank_bready_o,
    input  logic [SLAVE_NUM-1:0]            bank_rvalid_i,
    output logic [SLAVE_NUM-1:0]            bank_rready_o,
    input  axil_pkg::data_t [SLAVE_NUM-1:0] bank_rdata_i,

    output logic            bvalid_o,
    output axil_pkg::resp_t bresp_o,
    input  logic            bready_i,
    output logic            rvalid_o,
    output axil_pkg::data_t rdata_o,
    output axil_pkg::resp_t rresp_o,
    input  logic            rready_i,

    output logic wr_done_o,
    output logic rd_done_o
);

    import axil_pkg::*;
    import ctrl_map_pkg::*;

    logic                 wr_miss_pend;
    logic                 rd_miss_pend;
    logic [SLAVE_NUM-1:0] wr_onehot;
    logic [SLAVE_NUM-1:0] rd_onehot;
    logic                 wr_take;
    logic                 rd_take;
    data_t                rd_sel_data;

    always_comb begin
        rd_sel_data = '0;
        for (int i = 0; i < SLAVE_NUM; i++) begin
            wr_onehot[i] = (wr_sel_i == slave_idx_t'(i));
            rd_onehot[i] = (rd_sel_i == slave_idx_t'(i));
            if (rd_onehot[i]) rd_sel_data = bank_rdata_i[i];
        end
    end

    // a pending miss acts as a DECERR slave.
    assign bank_bready_o = {SLAVE_NUM{!bvalid_o && !wr_miss_pend}} & wr_onehot;
    assign bank_rready_o = {SLAVE_NUM{!rvalid_o && !rd_miss_pend}} & rd_onehot;

    assign wr_take = !bvalid_o && (wr_miss_pend || (|(bank_bvalid_i & wr_onehot)));
    assign rd_take = !rvalid_o && (rd_miss_pend || (|(bank_rvalid_i & rd_onehot)));

    assign wr_done_o = bvalid_o && bready_i;
    assign rd_done_o = rvalid_o && rready_i;

    // ~~~~~~~~~~~~~~~~~~~~
    // response registers
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_miss_pend <= 1'b0;
            rd_miss_pend <= 1'b0;
            bvalid_o     <= 1'b0;
            rvalid_o     <= 1'b0;
        end else begin
            if (wr_miss_i) wr_miss_pend <= 1'b1;
            else if (wr_take) wr_miss_pend <= 1'b0;
            if (rd_miss_i) rd_miss_pend <= 1'b1;
            else if (rd_take) rd_miss_pend <= 1'b0;

            if (wr_take) bvalid_o <= 1'b1;
            else if (wr_done_o) bvalid_o <= 1'b0;
            if (rd_take) rvalid_o <= 1'b1;
            else if (rd_done_o) rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_take) bresp_o <= wr_miss_pend ? RESP_DECERR : RESP_OKAY;
        if (rd_take) begin
            rresp_o <= rd_miss_pend ? RESP_DECERR : RESP_OKAY;
            rdata_o <= rd_miss_pend ? '0 : rd_sel_data;  // zero data on a miss.
        end
    end

endmodule

//--- verilog/ctrl_top.sv
module ctrl_top #(
    parameter int SLAVE_NUM = 3,
    parameter int REG_NUM   = 4
) (
    input  logic clk_i,
    input  logic rst_i,

    input  axil_pkg::addr_t awaddr_i,
    input  axil_pkg::prot_t awprot_i,  // accepted, not used.
    input  logic            awvalid_i,
    output logic            awready_o,
    input  axil_pkg::data_t wdata_i,
    input  axil_pkg::strb_t wstrb_i,
    input  logic            wvalid_i,
    output logic            wready_o,
    output logic            bvalid_o,
    output axil_pkg::resp_t bresp_o,
    input  logic            bready_i,

    input  axil_pkg::addr_t araddr_i,
    input  axil_pkg::prot_t arprot_i,  // accepted, not used.
    input  logic            arvalid_i,
    output logic            arready_o,
    output logic            rvalid_o,
    output axil_pkg::data_t rdata_o,
    output axil_pkg::resp_t rresp_o,
    input  logic            rready_i
);

    import axil_pkg::*;
    import ctrl_map_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // decoder to banks
    // ~~~~~~~~~~~~~~~~~~~~

    logic [SLAVE_NUM-1:0] wr_req_valid;
    logic [SLAVE_NUM-1:0] wr_req_ready;
    logic [SLAVE_NUM-1:0] rd_req_valid;
    logic [SLAVE_NUM-1:0] rd_req_ready;
    addr_t                wr_addr;
    data_t                wr_data;
    strb_t                wr_strb;
    addr_t                rd_addr;

    logic       wr_miss;
    logic       rd_miss;
    slave_idx_t wr_sel;
    slave_idx_t rd_sel;
    logic       wr_done;
    logic       rd_done;

    // ~~~~~~~~~~~~~~~~~~~~
    // banks to mux
    // ~~~~~~~~~~~~~~~~~~~~

    logic [SLAVE_NUM-1:0]  bank_bvalid;
    logic [SLAVE_NUM-1:0]  bank_bready;
    logic [SLAVE_NUM-1:0]  bank_rvalid;
    logic [SLAVE_NUM-1:0]  bank_rready;
    data_t [SLAVE_NUM-1:0] bank_rdata;

    axil_addr_decode #(
        .SLAVE_NUM(SLAVE_NUM)
    ) i_addr_decode (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .awaddr_i      (awaddr_i),
        .awvalid_i     (awvalid_i),
        .awready_o     (awready_o),
        .wdata_i       (wdata_i),
        .wstrb_i       (wstrb_i),
        .wvalid_i      (wvalid_i),
        .wready_o      (wready_o),
        .araddr_i      (araddr_i),
        .arvalid_i     (arvalid_i),
        .arready_o     (arready_o),
        .wr_req_valid_o(wr_req_valid),
        .wr_req_ready_i(wr_req_ready),
        .wr_addr_o     (wr_addr),
        .wr_data_o     (wr_data),
        .wr_strb_o     (wr_strb),
        .rd_req_valid_o(rd_req_valid),
        .rd_req_ready_i(rd_req_ready),
        .rd_addr_o     (rd_addr),
        .wr_miss_o     (wr_miss),
        .rd_miss_o     (rd_miss),
        .wr_sel_o      (wr_sel),
        .rd_sel_o      (rd_sel),
        .wr_done_i     (wr_done),
        .rd_done_i     (rd_done)
    );

    // one bank per 64 KiB window.
    for (genvar i = 0; i < SLAVE_NUM; i++) begin : g_bank
        axil_reg_bank #(
            .REG_NUM(REG_NUM)
        ) i_reg_bank (
            .clk_i     (clk_i),
            .rst_i     (rst_i),
            .wr_valid_i(wr_req_valid[i]),
            .wr_ready_o(wr_req_ready[i]),
            .wr_addr_i (wr_addr),
            .wr_data_i (wr_data),
            .wr_strb_i (wr_strb),
            .bvalid_o  (bank_bvalid[i]),
            .bready_i  (bank_bready[i]),
            .rd_valid_i(rd_req_valid[i]),
            .rd_ready_o(rd_req_ready[i]),
            .rd_addr_i (rd_addr),
            .rvalid_o  (bank_rvalid[i]),
            .rdata_o   (bank_rdata[i]),
            .rready_i  (bank_rready[i])
        );
    end

    axil_resp_mux #(
        .SLAVE_NUM(SLAVE_NUM)
    ) i_resp_mux (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .wr_sel_i     (wr_sel),
        .rd_sel_i     (rd_sel),
        .wr_miss_i    (wr_miss),
        .rd_miss_i    (rd_miss),
        .bank_bvalid_i(bank_bvalid),
        .bank_bready_o(bank_bready),
        .bank_rvalid_i(bank_rvalid),
        .bank_rready_o(bank_rready),
        .bank_rdata_i (bank_rdata),
        .bvalid_o     (bvalid_o),
        .bresp_o      (bresp_o),
        .bready_i     (bready_i),
        .rvalid_o     (rvalid_o),
        .rdata_o      (rdata_o),
        .rresp_o      (rresp_o),
        .rready_i     (rready_i),
        .wr_done_o    (wr_done),
        .rd_done_o    (rd_done)
    );

endmodule

//--- test/ctrl_top_sva.sv
module ctrl_top_sva (
    input logic            clk_i,
    input logic            rst_i,
    input axil_pkg::addr_t awaddr_i,
    input logic            awvalid_i,
    input logic            awready_o,
    input axil_pkg::data_t wdata_i,
    input axil_pkg::strb_t wstrb_i,
    input logic            wvalid_i,
    input logic            wready_o,
    input logic            bvalid_o,
    input axil_pkg::resp_t bresp_o,
    input logic            bready_i,
    input axil_pkg::addr_t araddr_i,
    input logic            arvalid_i,
    input logic            arready_o,
    input logic            rvalid_o,
    input axil_pkg::data_t rdata_o,
    input axil_pkg::resp_t rresp_o,
    input logic            rready_i
);

    int unsigned fail_cnt = 0;  // polled by the testbench.

    // ~~~~~~~~~~~~~~~~~~~~
    // request channels
    // ~~~~~~~~~~~~~~~~~~~~

    aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        awvalid_i && !awready_o |=> awvalid_i && $stable(awaddr_i))
        else begin
            fail_cnt++;
            $error("awvalid or awaddr changed before awready");
        end

    w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        wvalid_i && !wready_o |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
        else begin
            fail_cnt++;
            $error("wvalid or write payload changed before wready");
        end

    ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        arvalid_i && !arready_o |=> arvalid_i && $stable(araddr_i))
        else begin
            fail_cnt++;
            $error("arvalid or araddr changed before arready");
        end

    // ~~~~~~~~~~~~~~~~~~~~
    // response channels
    // ~~~~~~~~~~~~~~~~~~~~

    b_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
        else begin
            fail_cnt++;
            $error("bvalid or bresp changed before bready");
        end

    r_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
        else begin
            fail_cnt++;
            $error("rvalid or read payload changed before rready");
        end

    // registered valids are cleared by the reset edge.
    rst_quiet: assert property (@(posedge clk_i)
        rst_i |=> !bvalid_o && !rvalid_o)
        else begin
            fail_cnt++;
            $error("response valid high during reset");
        end

endmodule

bind ctrl_top ctrl_top_sva sva_i (.*);

//--- test/ctrl_top_tb.sv
module ctrl_top_tb;

    import axil_pkg::*;
    import ctrl_map_pkg::*;

    localparam int SLAVE_NUM      = 3;
    localparam int REG_NUM        = 4;
    localparam int OP_COUNT       = 300;
    localparam int TIMEOUT_CYCLES = 200;

    localparam addr_t MAP_END = CTRL_BASE_ADDR + addr_t'(SLAVE_NUM) * SLAVE_SPAN;

    logic  clk_i = 1'b0;
    logic  rst_i;
    addr_t awaddr_i;
    prot_t awprot_i;
    logic  awvalid_i;
    logic  awready_o;
    data_t wdata_i;
    strb_t wstrb_i;
    logic  wvalid_i;
    logic  wready_o;
    logic  bvalid_o;
    resp_t bresp_o;
    logic  bready_i;
    addr_t araddr_i;
    prot_t arprot_i;
    logic  arvalid_i;
    logic  arready_o;
    logic  rvalid_o;
    data_t rdata_o;
    resp_t rresp_o;
    logic  rready_i;

    logic [31:0] lcg_state = 32'd3602;
    data_t       model [SLAVE_NUM][REG_NUM];  // expected register contents.
    int          wr_reqs = 0;
    int          rd_reqs = 0;
    int          b_seen  = 0;
    int          r_seen  = 0;

    ctrl_top #(
        .SLAVE_NUM(SLAVE_NUM),
        .REG_NUM  (REG_NUM)
    ) dut_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .awaddr_i (awaddr_i),
        .awprot_i (awprot_i),
        .awvalid_i(awvalid_i),
        .awready_o(awready_o),
        .wdata_i  (wdata_i),
        .wstrb_i  (wstrb_i),
        .wvalid_i (wvalid_i),
        .wready_o (wready_o),
        .bvalid_o (bvalid_o),
        .bresp_o  (bresp_o),
        .bready_i (bready_i),
        .araddr_i (araddr_i),
        .arprot_i (arprot_i),
        .arvalid_i(arvalid_i),
        .arready_o(arready_o),
        .rvalid_o (rvalid_o),
        .rdata_o  (rdata_o),
        .rresp_o  (rresp_o),
        .rready_i (rready_i)
    );

    always #20 clk_i = ~clk_i;

    // ~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT_CYCLES);
        abort_run();
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic data_t rand_word();
        logic [31:0] a;
        logic [31:0] b;
        a = next_rand();
        b = next_rand();
        return {a[31:16], b[31:16]};
    endfunction

    function automatic logic ready_pick();
        logic [31:0] r;
        r = next_rand();
        return r[29:28] != 2'b00;  // stall one cycle in four.
    endfunction

    function automatic addr_t pick_addr();
        logic [31:0] r;
        logic [31:0] s;
        addr_t       win;
        r   = next_rand();
        s   = next_rand();
        win = CTRL_BASE_ADDR + addr_t'(int'(s[23:16]) % SLAVE_NUM) * SLAVE_SPAN;
        case (r[18:16])
            3'd0:    return CTRL_BASE_ADDR - {16'd0, s[27:16], 4'hc};  // below the map.
            3'd1:    return MAP_END + {14'd0, s[31:16], 2'b00};
            3'd2:    return {s[31:18], r[31:16], 2'b00};
            3'd3:    return win + {16'd0, s[31:18], 2'b00};  // upper offset bits set.
            default: return win + addr_t'(4 * (int'(r[27:20]) % REG_NUM));
        endcase
    endfunction

    // reference map.
    function automatic logic addr_in_map(input addr_t addr);
        return (addr >= CTRL_BASE_ADDR) && (addr < MAP_END);
    endfunction

    function automatic int window_of(input addr_t addr);
        return int'((addr - CTRL_BASE_ADDR) / SLAVE_SPAN);
    endfunction

    function automatic int word_of(input addr_t addr);
        return int'(((addr - CTRL_BASE_ADDR) % SLAVE_SPAN) / 4) % REG_NUM;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // bus transactions
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic write_op(input addr_t addr, input data_t data, input strb_t strb,
                            output resp_t resp);
        int    cycles;
        logic  held;
        logic  taken;
        resp_t held_resp;
        awaddr_i  <= addr;
        awprot_i  <= prot_t'(next_rand() >> 16);  // ignored by the DUT.
        wdata_i   <= data;
        wstrb_i   <= strb;
        awvalid_i <= 1'b1;
        wvalid_i  <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk_i);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) timeout_abort("awready and wready");
        end while (!(awready_o && wready_o));
        awvalid_i <= 1'b0;
        wvalid_i  <= 1'b0;
        wr_reqs++;
        cycles    = 0;
        held      = 1'b0;
        taken     = 1'b0;
        held_resp = '0;
        while (!taken) begin
            bready_i <= ready_pick();
            @(posedge clk_i);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) timeout_abort("write response");
            if (held) begin
                check(32'(bvalid_o), 1, "bvalid held until bready");
                check(32'(bresp_o), 32'(held_resp), "bresp stable under stall");
            end
            if (bvalid_o) begin
                if (!held) check(32'(cycles >= 3), 1, "write latency of 3 or more cycles");
                held      = 1'b1;
                held_resp = bresp_o;
                taken     = bready_i;
            end
        end
        bready_i <= 1'b1;  // stray responses still get taken and counted.
        @(posedge clk_i);
        check(32'(bvalid_o), 0, "bvalid drops after handshake");
        resp = held_resp;
    endtask

    task automatic read_op(input addr_t addr, output data_t data, output resp_t resp);
        int    cycles;
        logic  held;
        logic  taken;
        data_t held_data;
        resp_t held_resp;
        araddr_i  <= addr;
        arprot_i  <= prot_t'(next_rand() >> 16);
        arvalid_i <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk_i);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) timeout_abort("arready");
        end while (!arready_o);
        arvalid_i <= 1'b0;
        rd_reqs++;
        cycles    = 0;
        held      = 1'b0;
        taken     = 1'b0;
        held_data = '0;
        held_resp = '0;
        while (!taken) begin
            rready_i <= ready_pick();
            @(posedge clk_i);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) timeout_abort("read response");
            if (held) begin
                check(32'(rvalid_o), 1, "rvalid held until rready");
                check(rdata_o, held_data, "rdata stable under stall");
                check(32'(rresp_o), 32'(held_resp), "rresp stable under stall");
            end
            if (rvalid_o) begin
                if (!held) check(32'(cycles >= 3), 1, "read latency of 3 or more cycles");
                held      = 1'b1;
                held_data = rdata_o;
                held_resp = rresp_o;
                taken     = rready_i;
            end
        end
        rready_i <= 1'b1;
        @(posedge clk_i);
        check(32'(rvalid_o), 0, "rvalid drops after handshake");
        data = held_data;
        resp = held_resp;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // test sequences
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic sweep_check(input string phase);
        data_t got;
        resp_t resp;
        addr_t addr;
        for (int s = 0; s < SLAVE_NUM; s++) begin
            for (int w = 0; w < REG_NUM; w++) begin
                addr = CTRL_BASE_ADDR + addr_t'(s) * SLAVE_SPAN + addr_t'(4 * w);
                read_op(addr, got, resp);
                check(32'(resp), 32'(RESP_OKAY), $sformatf("%s rresp at %h", phase, addr));
                check(got, model[s][w], $sformatf("%s rdata at %h", phase, addr));
            end
        end
    endtask

    task automatic random_op();
        logic [31:0] r;
        addr_t       addr;
        data_t       data;
        strb_t       strb;
        data_t       got;
        resp_t       resp;
        logic        hit;
        int          s;
        int          w;
        r    = next_rand();
        addr = pick_addr();
        hit  = addr_in_map(addr);
        s    = hit ? window_of(addr) : 0;
        w    = hit ? word_of(addr) : 0;
        if (r[31]) begin
            data = rand_word();
            strb = strb_t'(r[27:24]);
            write_op(addr, data, strb, resp);
            if (hit) begin
                check(32'(resp), 32'(RESP_OKAY), $sformatf("bresp at %h", addr));
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (strb[b]) model[s][w][8*b+:8] = data[8*b+:8];
                end
            end else begin
                check(32'(resp), 32'(RESP_DECERR), $sformatf("bresp off map at %h", addr));
            end
        end else begin
            read_op(addr, got, resp);
            if (hit) begin
                check(32'(resp), 32'(RESP_OKAY), $sformatf("rresp at %h", addr));
                check(got, model[s][w], $sformatf("rdata at %h", addr));
            end else begin
                check(32'(resp), 32'(RESP_DECERR), $sformatf("rresp off map at %h", addr));
                check(got, 0, $sformatf("rdata off map at %h", addr));
            end
        end
    endtask

    // counts every master-side response, independent of the tasks.
    always @(posedge clk_i) begin
        if (!rst_i && bvalid_o && bready_i) b_seen++;
        if (!rst_i && rvalid_o && rready_i) r_seen++;
        if (dut_i.sva_i.fail_cnt != 0) begin
            $display("assertion failure reported by ctrl_top_sva");
            abort_run();
        end
    end

    initial begin
        rst_i     <= 1'b1;
        awaddr_i  <= '0;
        awprot_i  <= '0;
        awvalid_i <= 1'b0;
        wdata_i   <= '0;
        wstrb_i   <= '0;
        wvalid_i  <= 1'b0;
        bready_i  <= 1'b0;
        araddr_i  <= '0;
        arprot_i  <= '0;
        arvalid_i <= 1'b0;
        rready_i  <= 1'b0;
        for (int s = 0; s < SLAVE_NUM; s++) begin
            for (int w = 0; w < REG_NUM; w++) begin
                model[s][w] = '0;
            end
        end
        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;
        @(posedge clk_i);

        sweep_check("after reset");
        for (int n = 0; n < OP_COUNT; n++) begin
            random_op();
        end
        sweep_check("final");

        repeat (4) @(posedge clk_i);
        check(32'(b_seen), 32'(wr_reqs), "write responses vs write requests");
        check(32'(r_seen), 32'(rd_reqs), "read responses vs read requests");
        if (dut_i.sva_i.fail_cnt == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("assertion failures seen in ctrl_top_sva");
            abort_run();
        end
    end

endmodule

//--- files.f
common/axil_pkg.sv
common/ctrl_map_pkg.sv
reg_bank/axil_reg_bank.sv
verilog/axil_addr_decode.sv
verilog/axil_resp_mux.sv
verilog/ctrl_top.sv
test/ctrl_top_sva.sv
test/ctrl_top_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := ctrl_top_tb
FILELIST  := files.f

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run FAILED"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || { echo "run did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
